// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_smc_top
FILELIST = all.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+include
rtl/smc_bus_pkg.sv
rtl/smc_ctrl_pkg.sv
rtl/smc_access_if.sv
rtl/smc_wb_front.sv
rtl/smc_bank_engine.sv
rtl/smc_emi_merge.sv
rtl/smc_lite_top.sv
bench/smc_ext_mem.sv
bench/smc_assertions.sv
bench/tb_smc_top.sv

// File: bench/smc_assertions.sv
`timescale 1ns/1ps
`default_nettype none
`include "smc_cfg.svh"

module smc_assertions
(
   input logic                      sys_clk11,
   input logic                      n_sys_reset11,
   input logic [`SMC_NUM_BANKS-1:0] smc_n_cs,
   input logic [3:0]                smc_n_be,
   input logic                      wb_ack
);

   // Sticky flag for each property
   logic cs_onehot_bad = 1'b0;
   logic cs_be_bad     = 1'b0;
   logic ack_len_bad   = 1'b0;

   // --------------------------------------------------
   // External bus
   // --------------------------------------------------
   a_one_cs : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
      $countones(~smc_n_cs) <= 1)
   else
   begin
      cs_onehot_bad = 1'b1;
      $error("More than one chip select low %b", smc_n_cs);
   end

   // A selected bank always moves at least one lane
   a_cs_be : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
      (smc_n_cs != '1) |-> (smc_n_be != 4'b1111))
   else
   begin
      cs_be_bad = 1'b1;
      $error("Chip select low with no byte enable");
   end

   // Wishbone side
   a_ack_one : assert property (@(posedge sys_clk11) disable iff (!n_sys_reset11)
      wb_ack |=> !wb_ack)
   else
   begin
      ack_len_bad = 1'b1;          // Ack held two cycles
      $error("wb_ack longer than one cycle");
   end

endmodule

bind smc_emi_merge smc_assertions u_asrt
(
   .sys_clk11     (sys_clk11),
   .n_sys_reset11 (n_sys_reset11),
   .smc_n_cs      (smc_n_cs),
   .smc_n_be      (smc_n_be),
   .wb_ack        (wb_ack)
);

`default_nettype wire

// File: bench/smc_ext_mem.sv
`timescale 1ns/1ps
`default_nettype none

module smc_ext_mem
#(
   parameter int WIDTH = 32,        // Bus width of the bank in bits
   parameter int DEPTH = 64         // Bytes held
)
(
   input  logic        sys_clk11,
   input  logic        n_cs,
   input  logic        n_we,
   input  logic [3:0]  n_be,
   input  logic [31:0] addr,
   input  logic [31:0] wdata,
   output logic [31:0] rdata        // Zero while not selected
);

   localparam int LANES = WIDTH / 8;
   localparam int AW    = $clog2(DEPTH);

   logic [7:0]    mem [DEPTH];
   logic [AW-1:0] base;             // Byte seen on lane 0

   // Lane 0 sits on the bus-aligned byte
   assign base = addr[AW-1:0] & ~AW'(LANES - 1);

   // Fill pattern over every address bit
   initial
   begin
      for (int i = 0; i < DEPTH; i++)
         mem[AW'(i)] <= 8'(i) ^ 8'hC3;
   end

   // --------------------------------------------------
   // Write on enabled lanes, read all lanes of the bank
   // --------------------------------------------------
   always @(posedge sys_clk11)
   begin
      if (!n_cs && !n_we)
      begin
         for (int k = 0; k < LANES; k++)
         begin
            if (!n_be[2'(k)])
               mem[base + AW'(k)] <= 8'(wdata >> (8 * k));
         end
      end
   end

   always_comb
   begin
      rdata = '0;
      if (!n_cs)
      begin
         for (int k = 0; k < LANES; k++)
            rdata = rdata | (32'(mem[base + AW'(k)]) << (8 * k));   // Lanes above width stay 0
      end
   end

endmodule

`default_nettype wire

// File: bench/tb_smc_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "smc_cfg.svh"

module tb_smc_top
   import smc_bus_pkg::*;
();

   localparam int NUM_XFERS    = 300;
   localparam int XFER_TIMEOUT = 40;   // Longest transfer is under 20 cycles
   localparam int BANK_WIDTH [`SMC_NUM_BANKS] =
      '{`SMC_BANK0_WIDTH, `SMC_BANK1_WIDTH, `SMC_BANK2_WIDTH, `SMC_BANK3_WIDTH};

   logic        sys_clk11 = 1'b0;
   logic        n_sys_reset11;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [31:0] wb_adr;
   logic [3:0]  wb_sel;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   logic [31:0] smc_addr;
   logic [3:0]  smc_n_cs;
   logic [3:0]  smc_n_be;
   logic        smc_n_we;
   logic [31:0] smc_data_out;
   logic [31:0] smc_data_in;
   logic [31:0] mem_rdata [`SMC_NUM_BANKS];   // Zero while a bank is deselected
   logic [15:0] lfsr = 16'd56733;
   logic [7:0]  model [`SMC_NUM_BANKS][64];   // Expected bank contents
   int          xfer_no;

   always #5 sys_clk11 = ~sys_clk11;

   smc_lite_top u_dut
   (
      .sys_clk11     (sys_clk11),
      .n_sys_reset11 (n_sys_reset11),
      .wb_cyc        (wb_cyc),
      .wb_stb        (wb_stb),
      .wb_we         (wb_we),
      .wb_adr        (wb_adr),
      .wb_sel        (wb_sel),
      .wb_dat_w      (wb_dat_w),
      .wb_dat_r      (wb_dat_r),
      .wb_ack        (wb_ack),
      .smc_addr      (smc_addr),
      .smc_n_cs      (smc_n_cs),
      .smc_n_be      (smc_n_be),
      .smc_n_we      (smc_n_we),
      .smc_data_out  (smc_data_out),
      .smc_data_in   (smc_data_in)
   );

   for (genvar b = 0; b < `SMC_NUM_BANKS; b++)
   begin : g_mem
      smc_ext_mem #(.WIDTH(BANK_WIDTH[b])) u_mem
      (
         .sys_clk11 (sys_clk11),
         .n_cs      (smc_n_cs[b]),
         .n_we      (smc_n_we),
         .n_be      (smc_n_be),
         .addr      (smc_addr),
         .wdata     (smc_data_out),
         .rdata     (mem_rdata[b])
      );
   end

   always_comb
   begin
      smc_data_in = '0;
      for (int b = 0; b < `SMC_NUM_BANKS; b++)
         smc_data_in = smc_data_in | mem_rdata[b];
   end

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   // Fibonacci LFSR x^16+x^14+x^13+x^11+1 stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic smc_bus_size_e bus_of(input logic [1:0] bank);
      case (BANK_WIDTH[bank])
         8:       return BSIZ_8;
         16:      return BSIZ_16;
         default: return BSIZ_32;
      endcase
   endfunction

   // Active low lanes hit by nbytes bytes from offset lo
   function automatic logic [3:0] exp_be(input int lo, input int nbytes, input int lanes);
      logic [3:0] m;
      m = '0;
      for (int k = 0; k < nbytes; k++)
         m = m | 4'(1 << ((lo + k) % lanes));
      return ~m;
   endfunction

   function automatic logic asrt_fired();
      return u_dut.u_merge.u_asrt.cs_onehot_bad || u_dut.u_merge.u_asrt.cs_be_bad ||
             u_dut.u_merge.u_asrt.ack_len_bad;
   endfunction

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp)
         stop_on_error($sformatf("CHECK FAILED %s in transfer %0d: expected %h actual %h",
                                 name, xfer_no, exp, act));
   endtask

   task automatic check_be(input string name, input logic [3:0] exp, input logic [3:0] act,
                           input smc_xfer_size_e xs, input smc_bus_size_e bs);
      if (act !== exp)
         stop_on_error($sformatf("CHECK FAILED %s in transfer %0d (%s on %s): expected %b actual %b",
                                 name, xfer_no, xs.name(), bs.name(), exp, act));
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp)
         stop_on_error($sformatf("CHECK FAILED %s in transfer %0d: expected %0d actual %0d",
                                 name, xfer_no, exp, act));
   endtask

   task automatic check_idle_bus(input string name);
      check_word({name, " n_cs"}, 32'h0000_000F, 32'(smc_n_cs));
      check_word({name, " n_be"}, 32'h0000_000F, 32'(smc_n_be));
      check_word({name, " n_we"}, 32'h1, 32'(smc_n_we));
      check_word({name, " wb_ack"}, 32'h0, 32'(wb_ack));
   endtask

   // --------------------------------------------------
   // One Wishbone transfer watched cycle by cycle
   // --------------------------------------------------
   task automatic run_xfer(input logic [1:0] bank, input smc_xfer_size_e xs,
                           input logic [3:0] word, input logic [1:0] off,
                           input logic we, input logic [31:0] data);
      int            xbytes;
      int            lanes;
      int            chunk;       // Bytes per external access
      int            n_acc;
      int            acc;
      int            last_low;
      int            lo;
      logic [1:0]    base;
      logic [3:0]    sel;
      logic [3:0]    be_exp;
      logic [31:0]   adr;
      logic [31:0]   mask;
      logic [31:0]   exp_data;
      logic [31:0]   lane_exp;
      logic [31:0]   lane_mask;
      logic          cs_was_high;
      logic          got_ack;
      smc_bus_size_e bs;
      bs       = bus_of(bank);
      lanes    = BANK_WIDTH[bank] / 8;
      xbytes   = (xs == XSIZ_8) ? 1 : (xs == XSIZ_16) ? 2 : 4;
      base     = (xs == XSIZ_8) ? off : (xs == XSIZ_16) ? {off[1], 1'b0} : 2'b00;
      chunk    = (xbytes < lanes) ? xbytes : lanes;
      n_acc    = xbytes / chunk;
      adr      = {2'b00, bank, 22'd0, word, 2'b00};
      sel      = 4'(((1 << xbytes) - 1) << base);
      mask     = '0;
      exp_data = '0;
      for (int k = 0; k < 4; k++)
      begin
         if (sel[2'(k)])
         begin
            if (we)
               model[bank][{word, 2'(k)}] = 8'(data >> (8 * k));
            exp_data = exp_data | (32'(model[bank][{word, 2'(k)}]) << (8 * k));
            mask     = mask | (32'hFF << (8 * k));
         end
      end
      @(negedge sys_clk11);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_sel   = sel;
      wb_dat_w = data;
      cs_was_high = 1'b1;
      acc         = 0;
      last_low    = -1;
      got_ack     = 1'b0;
      for (int t = 0; t < XFER_TIMEOUT && !got_ack; t++)
      begin
         @(negedge sys_clk11);
         if (asrt_fired())
            stop_on_error("A protocol assertion on the external bus fired");
         if ((~smc_n_cs & ~(4'b0001 << bank)) != 4'b0000)
            stop_on_error("Chip select of a bank other than the addressed one went low");
         if (!smc_n_cs[bank])
         begin
            if (cs_was_high)
               acc++;                          // New access starts
            if (acc > n_acc)
               stop_on_error("More external accesses than the transfer needs");
            lo     = int'(base) + (n_acc - acc) * chunk;   // Top bytes first
            be_exp = exp_be(lo, chunk, lanes);
            check_be("smc_n_be", be_exp, smc_n_be, xs, bs);
            check_word("smc_addr", {adr[31:2], 2'(lo)}, smc_addr);
            check_word("smc_n_we", 32'(!we), 32'(smc_n_we));
            if (we)
            begin
               // Lane k carries the byte at the bus-aligned address plus k
               lane_exp  = '0;
               lane_mask = '0;
               for (int k = 0; k < lanes; k++)
               begin
                  if (!be_exp[2'(k)])
                  begin
                     lane_exp  = lane_exp |
                                 (32'(8'(data >> (8 * ((lo / lanes) * lanes + k)))) << (8 * k));
                     lane_mask = lane_mask | (32'hFF << (8 * k));
                  end
               end
               check_word("smc_data_out", lane_exp, smc_data_out & lane_mask);
            end
            last_low = t;
         end
         else
            check_word("smc_n_we while deselected", 32'h1, 32'(smc_n_we));
         cs_was_high = smc_n_cs[bank];
         if (wb_ack)
         begin
            got_ack = 1'b1;
            check_count("access count", n_acc, acc);
            check_count("ack cycle", last_low + 1, t);
            if (!we)
               check_word("read data", exp_data & mask, wb_dat_r & mask);
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
         end
      end
      if (!got_ack)
         stop_on_error("Timed out waiting for wb_ack");
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial
   begin
      logic [1:0]     bank;
      logic [1:0]     sz;
      logic [3:0]     word;
      logic [1:0]     off;
      logic           we;
      logic [31:0]    data;
      smc_xfer_size_e xs;
      n_sys_reset11 = 1'b0;
      wb_cyc        = 1'b0;
      wb_stb        = 1'b0;
      wb_we         = 1'b0;
      wb_adr        = '0;
      wb_sel        = '0;
      wb_dat_w      = '0;
      xfer_no       = 0;
      for (int b = 0; b < `SMC_NUM_BANKS; b++)
         for (int i = 0; i < 64; i++)
            model[2'(b)][6'(i)] = 8'(i) ^ 8'hC3;   // Power-up contents of the memories
      repeat (16)
      begin
         @(negedge sys_clk11);
         check_idle_bus("in reset");
      end
      n_sys_reset11 = 1'b1;
      repeat (4)
      begin
         @(negedge sys_clk11);
         check_idle_bus("after reset");
      end
      for (int n = 0; n < NUM_XFERS; n++)
      begin
         xfer_no = n;
         bank    = 2'(rand_bits(2));
         sz      = 2'(rand_bits(2));
         xs      = (sz == 2'd0) ? XSIZ_8 : (sz == 2'd1) ? XSIZ_16 : XSIZ_32;
         word    = 4'(rand_bits(4));   // Small window so reads hit earlier writes
         off     = 2'(rand_bits(2));
         we      = 1'(rand_bits(1));
         data    = rand_bits(32);
         run_xfer(bank, xs, word, off, we, data);
      end
      @(negedge sys_clk11);
      if (asrt_fired())
      begin
         $display("A protocol assertion on the external bus fired");
         $display(">>> FAIL");
         $fatal(1, "Simulation stopped on an assertion");
      end
      else
      begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: include/smc_cfg.svh
`ifndef SMC_CFG_SVH
`define SMC_CFG_SVH

// Bank map
`define SMC_NUM_BANKS      4      // External chip selects
`define SMC_BANK_LSB       28     // Wishbone address bits picking the bank
`define SMC_BANK_MSB       29

// External access timing
`define SMC_ACCESS_CYCLES  2      // Chip select low cycles per access

// Data width of each bank in bits
`define SMC_BANK0_WIDTH    8
`define SMC_BANK1_WIDTH    16
`define SMC_BANK2_WIDTH    32
`define SMC_BANK3_WIDTH    32

`endif

// File: rtl/smc_access_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "smc_cfg.svh"

// Request from the Wishbone front end to all banks
interface smc_req_if
   import smc_bus_pkg::*;
();
   logic [`SMC_NUM_BANKS-1:0] start;      // One hot pulse per request
   logic [31:0]               addr;       // Byte address with low bits from sel
   smc_xfer_size_e            xfer_size;
   logic                      we;
   logic [31:0]               wdata;

   modport front (output start, output addr, output xfer_size, output we, output wdata);
   modport bank  (input start, input addr, input xfer_size, input we, input wdata);
endinterface

// External pins of one bank plus its completion
interface smc_emi_if;
   logic        n_cs;
   logic [31:0] addr;      // Zero while idle
   logic [3:0]  n_be;      // Active low lane enables
   logic        n_we;
   logic [31:0] wdata;     // Zero while idle
   logic        done;      // Last RW cycle of the transfer
   logic [31:0] rdata;     // Assembled Wishbone word

   modport bank  (output n_cs, output addr, output n_be, output n_we,
                  output wdata, output done, output rdata);
   modport merge (input n_cs, input addr, input n_be, input n_we,
                  input wdata, input done, input rdata);
endinterface

`default_nettype wire

// File: rtl/smc_bank_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "smc_cfg.svh"

module smc_bank_engine
   import smc_bus_pkg::*, smc_ctrl_pkg::*;
#(
   parameter smc_bus_size_e BUS_SIZE = BSIZ_32,   // Width of this bank
   parameter int            BANK     = 0          // Start bit to follow
)
(
   input  logic        sys_clk11,
   input  logic        n_sys_reset11,
   smc_req_if.bank     req,
   smc_emi_if.bank     emi,
   input  logic [31:0] smc_data_in     // Shared read lanes
);

   localparam int CYC_W = (`SMC_ACCESS_CYCLES > 1) ? $clog2(`SMC_ACCESS_CYCLES) : 1;
   localparam logic [CYC_W-1:0] CYC_LAST = CYC_W'(`SMC_ACCESS_CYCLES - 1);

   smc_state_e       state;
   logic [1:0]       acc_left;      // Accesses still to go after this one
   logic [CYC_W-1:0] cyc_cnt;       // Position inside RW
   logic [1:0]       addr_lo;       // Low address bits of the request
   logic [1:0]       cur_lo;        // Low address bits of this access
   logic             last_cyc;
   logic [3:0]       be_pat;
   logic [31:0]      wr_lanes;
   logic [31:0]      rd_hold;       // Bytes of earlier accesses
   logic [31:0]      rd_next;

   // Index of the last access for a transfer on this bank
   function automatic logic [1:0] last_access(input smc_xfer_size_e xs);
      logic [1:0] n;
      n = 2'd0;
      if (xs == XSIZ_32 && BUS_SIZE == BSIZ_8)
         n = 2'd3;
      else if (xs == XSIZ_32 && BUS_SIZE == BSIZ_16)
         n = 2'd1;
      else if (xs == XSIZ_16 && BUS_SIZE == BSIZ_8)
         n = 2'd1;
      return n;
   endfunction

   assign last_cyc = (cyc_cnt == CYC_LAST);

   // --------------------------------------------------
   // Access sequencer
   // --------------------------------------------------
   always_ff @(posedge sys_clk11 or negedge n_sys_reset11)
   begin
      if (!n_sys_reset11)
      begin
         state    <= IDLE;
         acc_left <= 2'd0;
         cyc_cnt  <= '0;
         addr_lo  <= 2'd0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (req.start[BANK])
               begin
                  state    <= SETUP;
                  acc_left <= last_access(req.xfer_size);
                  addr_lo  <= req.addr[1:0];
               end
            end
            SETUP:
            begin
               state   <= RW;
               cyc_cnt <= '0;
            end
            RW:
            begin
               if (!last_cyc)
                  cyc_cnt <= cyc_cnt + 1'b1;
               else if (acc_left == 2'd0)
                  state <= IDLE;               // Last access skips GAP
               else
               begin
                  state    <= GAP;
                  acc_left <= acc_left - 2'd1;
               end
            end
            GAP:
            begin
               state <= SETUP;
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   // --------------------------------------------------
   // Address order is little endian from the top byte down
   // --------------------------------------------------
   always_comb
   begin
      case ({req.xfer_size, BUS_SIZE})
         {XSIZ_32, BSIZ_8}:  cur_lo = acc_left;                  // 3 2 1 0
         {XSIZ_32, BSIZ_16}: cur_lo = {acc_left[0], 1'b0};       // 2 0
         {XSIZ_32, BSIZ_32}: cur_lo = 2'b00;
         {XSIZ_16, BSIZ_8}:  cur_lo = {addr_lo[1], acc_left[0]}; // Odd byte first
         {XSIZ_16, BSIZ_16}: cur_lo = {addr_lo[1], 1'b0};
         {XSIZ_16, BSIZ_32}: cur_lo = {addr_lo[1], 1'b0};
         default:            cur_lo = addr_lo;                   // Byte transfers
      endcase
   end

   // Byte enable table
   always_comb
   begin
      case ({req.xfer_size, BUS_SIZE})
         {XSIZ_8, BSIZ_8}:   be_pat = 4'b1110;
         {XSIZ_8, BSIZ_16}:  be_pat = cur_lo[0] ? 4'b1101 : 4'b1110;
         {XSIZ_8, BSIZ_32}:  be_pat = ~(4'b0001 << cur_lo);      // Lane equals offset
         {XSIZ_16, BSIZ_8}:  be_pat = 4'b1110;
         {XSIZ_16, BSIZ_16}: be_pat = 4'b1100;
         {XSIZ_16, BSIZ_32}: be_pat = cur_lo[1] ? 4'b0011 : 4'b1100;
         {XSIZ_32, BSIZ_8}:  be_pat = 4'b1110;
         {XSIZ_32, BSIZ_16}: be_pat = 4'b1100;
         {XSIZ_32, BSIZ_32}: be_pat = 4'b0000;
         default:            be_pat = 4'b1111;                   // Bad decode
      endcase
   end

   // --------------------------------------------------
   // Data lanes
   // --------------------------------------------------
   always_comb
   begin
      wr_lanes = '0;
      case (BUS_SIZE)
         BSIZ_8:  wr_lanes[7:0]  = req.wdata[{cur_lo, 3'b000} +: 8];
         BSIZ_16: wr_lanes[15:0] = req.wdata[{cur_lo[1], 4'b0000} +: 16];
         default: wr_lanes       = req.wdata;
      endcase
   end

   // Current lanes laid over the bytes already collected
   always_comb
   begin
      rd_next = rd_hold;
      case (BUS_SIZE)
         BSIZ_8:  rd_next[{cur_lo, 3'b000} +: 8]     = smc_data_in[7:0];
         BSIZ_16: rd_next[{cur_lo[1], 4'b0000} +: 16] = smc_data_in[15:0];
         default: rd_next                             = smc_data_in;
      endcase
   end

   always_ff @(posedge sys_clk11)
   begin
      if (state == RW && last_cyc)
         rd_hold <= rd_next;             // Sample at the end of each access
   end

   // External pins of this bank
   assign emi.n_cs  = (state != RW);
   assign emi.n_we  = !(state == RW && req.we);
   assign emi.n_be  = (state == RW) ? be_pat : 4'b1111;
   assign emi.addr  = (state == IDLE) ? 32'h0 : {req.addr[31:2], cur_lo};
   assign emi.wdata = (state != IDLE && req.we) ? wr_lanes : 32'h0;
   assign emi.done  = (state == RW) && last_cyc && (acc_left == 2'd0);
   assign emi.rdata = rd_next;

endmodule

`default_nettype wire

// File: rtl/smc_bus_pkg.sv
`default_nettype none

package smc_bus_pkg;

   // Size of one Wishbone transfer
   typedef enum logic [1:0]
   {
      XSIZ_8  = 2'b00,
      XSIZ_16 = 2'b01,
      XSIZ_32 = 2'b10
   } smc_xfer_size_e;

   // Data width of an external bank
   typedef enum logic [1:0]
   {
      BSIZ_8  = 2'b00,
      BSIZ_16 = 2'b01,
      BSIZ_32 = 2'b10
   } smc_bus_size_e;

   // Map a width in bits onto the bank size code
   function automatic smc_bus_size_e width_to_bus_size(input int unsigned width);
      case (width)
         8:       return BSIZ_8;
         16:      return BSIZ_16;
         default: return BSIZ_32;         // Anything else runs full width
      endcase
   endfunction

endpackage

`default_nettype wire

// File: rtl/smc_ctrl_pkg.sv
`default_nettype none

package smc_ctrl_pkg;

   // --------------------------------------------------
   // Bank engine sequencing
   // --------------------------------------------------
   // One access is SETUP, then RW with chip select low,
   // then GAP unless it was the last one

   typedef enum logic [1:0]
   {
      IDLE  = 2'b00,    // Waiting for start
      SETUP = 2'b01,    // Address out, chip select high
      RW    = 2'b10,    // Chip select and strobes low
      GAP   = 2'b11     // Recovery between accesses
   } smc_state_e;

endpackage

`default_nettype wire

// File: rtl/smc_emi_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "smc_cfg.svh"

module smc_emi_merge
(
   input  logic        sys_clk11,
   input  logic        n_sys_reset11,
   smc_emi_if.merge    emi [`SMC_NUM_BANKS],
   output logic [31:0] smc_addr,
   output logic [`SMC_NUM_BANKS-1:0] smc_n_cs,
   output logic [3:0]  smc_n_be,
   output logic        smc_n_we,
   output logic [31:0] smc_data_out,
   output logic [31:0] wb_dat_r,
   output logic        wb_ack,
   output logic        ack_out       // Frees the front end
);

   localparam int NB = `SMC_NUM_BANKS;

   logic [31:0]   addr_arr  [NB];
   logic [3:0]    n_be_arr  [NB];
   logic [31:0]   wdata_arr [NB];
   logic [31:0]   rdata_arr [NB];
   logic [NB-1:0] n_we_vec;
   logic [NB-1:0] done_vec;
   logic [31:0]   rdata_sel;      // Word of the finishing bank

   // Pull the interface array apart
   for (genvar i = 0; i < NB; i++)
   begin : g_tap
      assign smc_n_cs[i]  = emi[i].n_cs;
      assign addr_arr[i]  = emi[i].addr;
      assign n_be_arr[i]  = emi[i].n_be;
      assign n_we_vec[i]  = emi[i].n_we;
      assign wdata_arr[i] = emi[i].wdata;
      assign done_vec[i]  = emi[i].done;
      assign rdata_arr[i] = emi[i].rdata;
   end

   // --------------------------------------------------
   // Shared bus with idle banks kept neutral
   // --------------------------------------------------
   always_comb
   begin
      smc_addr     = '0;
      smc_n_be     = '1;
      smc_data_out = '0;
      rdata_sel    = '0;
      for (int i = 0; i < NB; i++)
      begin
         smc_addr     = smc_addr | addr_arr[i];
         smc_n_be     = smc_n_be & n_be_arr[i];        // Low wins
         smc_data_out = smc_data_out | wdata_arr[i];
         if (done_vec[i])
            rdata_sel = rdata_sel | rdata_arr[i];
      end
   end

   assign smc_n_we = &n_we_vec;

   // Wishbone return path
   always_ff @(posedge sys_clk11 or negedge n_sys_reset11)
   begin
      if (!n_sys_reset11)
         wb_ack <= 1'b0;
      else
         wb_ack <= |done_vec;             // One cycle after the last RW
   end

   always_ff @(posedge sys_clk11)
   begin
      if (|done_vec)
         wb_dat_r <= rdata_sel;
   end

   assign ack_out = wb_ack;

endmodule

`default_nettype wire

// File: rtl/smc_lite_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "smc_cfg.svh"

module smc_lite_top
   import smc_bus_pkg::*;
(
   input  logic        sys_clk11,
   input  logic        n_sys_reset11,
   // Wishbone slave
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [31:0] wb_adr,
   input  logic [3:0]  wb_sel,
   input  logic [31:0] wb_dat_w,
   output logic [31:0] wb_dat_r,
   output logic        wb_ack,
   // External memory bus
   output logic [31:0] smc_addr,
   output logic [3:0]  smc_n_cs,
   output logic [3:0]  smc_n_be,
   output logic        smc_n_we,
   output logic [31:0] smc_data_out,
   input  logic [31:0] smc_data_in
);

   localparam int unsigned BANK_WIDTH [`SMC_NUM_BANKS] =
      '{`SMC_BANK0_WIDTH, `SMC_BANK1_WIDTH, `SMC_BANK2_WIDTH, `SMC_BANK3_WIDTH};

   logic ack;                            // Merger back to front end

   smc_req_if req ();
   smc_emi_if emi [`SMC_NUM_BANKS] ();

   smc_wb_front u_front
   (
      .sys_clk11     (sys_clk11),
      .n_sys_reset11 (n_sys_reset11),
      .wb_cyc        (wb_cyc),
      .wb_stb        (wb_stb),
      .wb_we         (wb_we),
      .wb_adr        (wb_adr),
      .wb_sel        (wb_sel),
      .wb_dat_w      (wb_dat_w),
      .ack_in        (ack),
      .req           (req)
   );

   for (genvar i = 0; i < `SMC_NUM_BANKS; i++)
   begin : g_bank
      smc_bank_engine
      #(
         .BUS_SIZE (width_to_bus_size(BANK_WIDTH[i])),
         .BANK     (i)
      )
      u_bank
      (
         .sys_clk11     (sys_clk11),
         .n_sys_reset11 (n_sys_reset11),
         .req           (req),
         .emi           (emi[i]),
         .smc_data_in   (smc_data_in)
      );
   end

   smc_emi_merge u_merge
   (
      .sys_clk11     (sys_clk11),
      .n_sys_reset11 (n_sys_reset11),
      .emi           (emi),
      .smc_addr      (smc_addr),
      .smc_n_cs      (smc_n_cs),
      .smc_n_be      (smc_n_be),
      .smc_n_we      (smc_n_we),
      .smc_data_out  (smc_data_out),
      .wb_dat_r      (wb_dat_r),
      .wb_ack        (wb_ack),
      .ack_out       (ack)
   );

endmodule

`default_nettype wire

// File: rtl/smc_wb_front.sv
`timescale 1ns/1ps
`default_nettype none
`include "smc_cfg.svh"

module smc_wb_front
   import smc_bus_pkg::*;
(
   input  logic        sys_clk11,
   input  logic        n_sys_reset11,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [31:0] wb_adr,
   input  logic [3:0]  wb_sel,
   input  logic [31:0] wb_dat_w,
   input  logic        ack_in,        // Registered ack from the merger
   smc_req_if.front    req
);

   logic                                       busy;      // Request in flight
   logic                                       accept;
   logic [`SMC_BANK_MSB-`SMC_BANK_LSB:0]       bank_sel;
   smc_xfer_size_e                             sel_size;
   logic [1:0]                                 sel_lo;    // Byte offset from sel

   assign accept   = wb_cyc && wb_stb && !busy;
   assign bank_sel = wb_adr[`SMC_BANK_MSB:`SMC_BANK_LSB];

   // --------------------------------------------------
   // Transfer size and offset from the byte selects
   // --------------------------------------------------
   always_comb
   begin
      sel_size = XSIZ_32;                 // Odd patterns fall back to a word
      sel_lo   = 2'b00;
      case (wb_sel)
         4'b0001:
         begin
            sel_size = XSIZ_8;
         end
         4'b0010:
         begin
            sel_size = XSIZ_8;
            sel_lo   = 2'b01;
         end
         4'b0100:
         begin
            sel_size = XSIZ_8;
            sel_lo   = 2'b10;
         end
         4'b1000:
         begin
            sel_size = XSIZ_8;
            sel_lo   = 2'b11;
         end
         4'b0011:
         begin
            sel_size = XSIZ_16;           // Lower half word
         end
         4'b1100:
         begin
            sel_size = XSIZ_16;           // Upper half word
            sel_lo   = 2'b10;
         end
         default:
         begin
            sel_size = XSIZ_32;
            sel_lo   = 2'b00;
         end
      endcase
   end

   // --------------------------------------------------
   // Handshake and start pulse
   // --------------------------------------------------
   always_ff @(posedge sys_clk11 or negedge n_sys_reset11)
   begin
      if (!n_sys_reset11)
      begin
         busy      <= 1'b0;
         req.start <= '0;
      end
      else
      begin
         req.start <= '0;                 // Held for one cycle only
         if (accept)
         begin
            busy                <= 1'b1;
            req.start[bank_sel] <= 1'b1;
         end
         else if (ack_in)
            busy <= 1'b0;                 // Free again after the ack cycle
      end
   end

   // Request fields held stable until the bank is done
   always_ff @(posedge sys_clk11)
   begin
      if (accept)
      begin
         req.addr      <= {wb_adr[31:2], sel_lo};
         req.xfer_size <= sel_size;
         req.we        <= wb_we;
         req.wdata     <= wb_dat_w;
      end
   end

endmodule

`default_nettype wire
